//--- Makefile
TOP := alu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/alu_props.sv
`timescale 1ns/10ps

module alu_props #(
    parameter bit has_handshake = 1'b1
) (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack,
    input logic pulse
);

    if (has_handshake) begin : g_handshake
        // ack only answers a request that was present at the edge before
        ack_rise_on_req: assert property (@(posedge clk) disable iff (rst)
            $rose(ack) |-> $past(req))
            else $error("ack rose without a request");

        ack_hold: assert property (@(posedge clk) disable iff (rst)
            ack && req |=> ack)
            else $error("ack fell while req was still high");
    end

    pulse_single: assert property (@(posedge clk) disable iff (rst)
        pulse |=> !pulse)
        else $error("result pulse stayed high for two cycles");

endmodule

bind alu_issue_reg alu_props u_issue_props (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .ack   (ack),
    .pulse (issue_valid)
);

// Only the writeback pulse is watched in alu_exec
bind alu_exec alu_props #(.has_handshake(1'b0)) u_exec_props (
    .clk   (clk),
    .rst   (rst),
    .req   (),
    .ack   (),
    .pulse (wb.en)
);

//--- bench/alu_tb.sv
`timescale 1ns/10ps

module alu_tb;

    localparam int clk_period = 8;
    localparam int n_iter = 12;
    // One handshake op, then 10 + 6 + 2 + 4 + 2 ops per iteration
    localparam int n_ops = 1 + 24 * n_iter;

    logic                    clk;
    logic                    rst;
    logic                    req;
    exec_pkg::issue_bundle_t in_bundle;
    logic                    ack;
    exec_pkg::wb_data_t      wb;
    exec_pkg::branch_res_t   br;

    exec_pkg::wb_data_t      got_wb;
    exec_pkg::branch_res_t   got_br;
    int                      ack_wait;
    int                      wb_lat;
    logic                    ack_at_wb;
    int                      errors;
    int                      checks;
    integer                  seed;

    alu_top uut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .in_bundle (in_bundle),
        .ack       (ack),
        .wb        (wb),
        .br        (br)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((n_ops * 10 + 100) * clk_period);
        $display("Watchdog expired: the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic make_bundle(output exec_pkg::issue_bundle_t b);
        logic [31:0] r;
        b = '0;
        r = rnd();
        b.rob_idx = r[4:0];
        b.rd = r[9:5];
        b.we = r[10];
        b.imm.u_form = r[31:12];
        b.rs1_data = rnd();
        b.rs2_data = rnd();
        r = rnd();
        b.pc = {r[31:2], 2'b00};   // Instructions are word aligned
        b.pred.target = rnd();
    endtask

    function automatic logic [31:0] model_int(input exec_pkg::issue_bundle_t b);
        logic [31:0] op2;
        logic [31:0] upper;
        logic [4:0]  sh;
        logic [31:0] r;
        op2 = b.immv ? {{20{b.imm.i_form.imm[11]}}, b.imm.i_form.imm} : b.rs2_data;
        upper = {b.imm.u_form, 12'h000};
        sh = op2[4:0];
        case (b.int_op)
            exec_pkg::int_add:   r = b.rs1_data + op2;
            exec_pkg::int_sub:   r = b.rs1_data - op2;
            exec_pkg::int_slt: begin
                if (b.uext) r = {31'b0, b.rs1_data < op2};
                else r = {31'b0, $signed(b.rs1_data) < $signed(op2)};
            end
            exec_pkg::int_or:    r = b.rs1_data | op2;
            exec_pkg::int_xor:   r = b.rs1_data ^ op2;
            exec_pkg::int_and:   r = b.rs1_data & op2;
            exec_pkg::int_sl:    r = b.rs1_data << sh;
            exec_pkg::int_sr: begin
                if (b.uext) r = b.rs1_data >> sh;
                else r = $signed(b.rs1_data) >>> sh;
            end
            exec_pkg::int_lui:   r = upper;
            exec_pkg::int_auipc: r = b.pc + upper;
            default:             r = '0;
        endcase
        return r;
    endfunction

    function automatic exec_pkg::branch_res_t model_branch(input exec_pkg::issue_bundle_t b);
        exec_pkg::branch_res_t r;
        logic                  lt;
        logic [31:0]           off;
        logic [31:0]           jalr_t;
        lt = b.uext ? (b.rs1_data < b.rs2_data) : ($signed(b.rs1_data) < $signed(b.rs2_data));
        off = {{19{b.imm.b_form.off[12]}}, b.imm.b_form.off[12:1], 1'b0};
        jalr_t = (b.rs1_data + {{20{b.imm.i_form.imm[11]}}, b.imm.i_form.imm}) & 32'hffff_fffe;
        r.en = 1'b1;
        case (b.br_op)
            exec_pkg::br_beq: r.direction = b.rs1_data == b.rs2_data;
            exec_pkg::br_bne: r.direction = b.rs1_data != b.rs2_data;
            exec_pkg::br_blt: r.direction = lt;
            exec_pkg::br_bge: r.direction = !lt;
            default:          r.direction = 1'b1;
        endcase
        if (b.br_op == exec_pkg::br_jalr) r.target = jalr_t;
        else r.target = r.direction ? b.pc + off : b.pc + 32'd4;
        if (b.br_op == exec_pkg::br_jalr) begin
            r.error = !b.pred.taken || (b.pred.target != r.target);
        end else if (b.br_op == exec_pkg::br_jal) begin
            r.error = 1'b0;
        end else begin
            r.error = (b.pred.taken != r.direction)
                   || (b.pred.taken && r.direction && b.pred.target != r.target);
        end
        return r;
    endfunction

    // Four-phase exchange, then collect the writeback pulse
    task automatic run_op(input exec_pkg::issue_bundle_t b);
        in_bundle = b;
        req = 1'b1;
        ack_wait = 0;
        @(negedge clk);
        while (!ack && ack_wait < 20) begin
            @(negedge clk);
            ack_wait++;
        end
        if (!ack) begin
            errors++;
            $display("Timeout at %0t: ack never rose after req", $time);
        end
        req = 1'b0;
        in_bundle.rs1_data = ~b.rs1_data;   // Captured copy must not follow the input
        in_bundle.rs2_data = ~b.rs2_data;
        wb_lat = 1;
        @(negedge clk);
        while (!wb.en && wb_lat < 20) begin
            @(negedge clk);
            wb_lat++;
        end
        if (!wb.en) begin
            errors++;
            $display("Timeout at %0t: no writeback pulse arrived", $time);
        end
        got_wb = wb;
        got_br = br;
        ack_at_wb = ack;
        while (ack) @(negedge clk);
    endtask

    task automatic check_result(input exec_pkg::issue_bundle_t b);
        exec_pkg::branch_res_t exp_br;
        logic [31:0]           exp_res;
        exp_br = model_branch(b);
        exp_res = b.intv ? model_int(b) : b.pc + 32'd4;
        check("wb.res", got_wb.res, exp_res);
        check("wb.we", 32'(got_wb.we), 32'(b.we));
        check("wb.rob_idx", 32'(got_wb.rob_idx), 32'(b.rob_idx));
        check("wb.rd", 32'(got_wb.rd), 32'(b.rd));
        check("br.en", 32'(got_br.en), 32'(!b.intv));
        if (!b.intv) begin
            check("br.direction", 32'(got_br.direction), 32'(exp_br.direction));
            check("br.target", got_br.target, exp_br.target);
            check("br.error", 32'(got_br.error), 32'(exp_br.error));
        end
    endtask

    task automatic test_reset_handshake();
        exec_pkg::issue_bundle_t b;
        check("ack after reset", 32'(ack), 32'd0);
        check("wb.en after reset", 32'(wb.en), 32'd0);
        check("br.en after reset", 32'(br.en), 32'd0);
        make_bundle(b);
        b.intv = 1'b1;
        b.int_op = exec_pkg::int_add;
        run_op(b);
        check("ack wait cycles", ack_wait, 32'd0);
        check("wb.en latency", wb_lat, 32'd1);
        check("ack at writeback", 32'(ack_at_wb), 32'd0);
        check_result(b);
    endtask

    task automatic test_arith();
        exec_pkg::issue_bundle_t b;
        exec_pkg::int_op_e       ops [5];
        ops = '{exec_pkg::int_add, exec_pkg::int_sub, exec_pkg::int_and,
                exec_pkg::int_or, exec_pkg::int_xor};
        for (int k = 0; k < 10 * n_iter; k++) begin
            make_bundle(b);
            b.intv = 1'b1;
            b.int_op = ops[k % 5];
            b.immv = k[0];
            run_op(b);
            check_result(b);
        end
    endtask

    task automatic test_compare_shift();
        exec_pkg::issue_bundle_t b;
        for (int k = 0; k < 6 * n_iter; k++) begin
            make_bundle(b);
            b.intv = 1'b1;
            b.uext = k[0];
            if (k < 2 * n_iter) begin
                b.int_op = exec_pkg::int_slt;
                b.rs1_data[31] = k[1];   // Mixed signs on every other pair
                b.rs2_data[31] = k[1] ^ k[2];
            end else begin
                b.int_op = k[1] ? exec_pkg::int_sr : exec_pkg::int_sl;
                b.immv = k[2];
            end
            run_op(b);
            check_result(b);
        end
    endtask

    task automatic test_upper();
        exec_pkg::issue_bundle_t b;
        for (int k = 0; k < 2 * n_iter; k++) begin
            make_bundle(b);
            b.intv = 1'b1;
            b.int_op = k[0] ? exec_pkg::int_auipc : exec_pkg::int_lui;
            run_op(b);
            check_result(b);
        end
    endtask

    task automatic test_branches(input int count, input logic jumps);
        exec_pkg::issue_bundle_t b;
        exec_pkg::branch_res_t   r;
        exec_pkg::br_op_e        ops [4];
        ops = '{exec_pkg::br_beq, exec_pkg::br_bne, exec_pkg::br_blt, exec_pkg::br_bge};
        for (int k = 0; k < count; k++) begin
            make_bundle(b);
            b.intv = 1'b0;
            b.uext = k[2];
            if (jumps) b.br_op = k[0] ? exec_pkg::br_jalr : exec_pkg::br_jal;
            else b.br_op = ops[k % 4];
            if (k[3]) b.rs2_data = b.rs1_data;
            r = model_branch(b);
            case ((k / 2) % 3)
                0: begin
                    b.pred.taken = r.direction;
                    b.pred.target = r.target;
                end
                1: begin
                    b.pred.taken = !r.direction;
                    b.pred.target = r.target;
                end
                default: begin
                    b.pred.taken = 1'b1;
                    b.pred.target = r.target ^ 32'h0000_0010;   // Taken to the wrong place
                end
            endcase
            run_op(b);
            check_result(b);
        end
    endtask

    initial begin
        seed = 32'h9aed2204;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        req = 1'b0;
        in_bundle = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        test_reset_handshake();
        test_arith();
        test_compare_shift();
        test_upper();
        test_branches(4 * n_iter, 1'b0);
        test_branches(2 * n_iter, 1'b1);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- project.f
verilog/exec_pkg.sv
verilog/alu_issue_reg.sv
verilog/int_alu.sv
verilog/branch_unit.sv
verilog/alu_exec.sv
verilog/alu_top.sv
bench/alu_props.sv
bench/alu_tb.sv

//--- verilog/alu_exec.sv
`timescale 1ns/10ps

module alu_exec (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  exec_pkg::issue_bundle_t bundle,
    output exec_pkg::wb_data_t      wb,
    output exec_pkg::branch_res_t   br
);

    logic [exec_pkg::xlen-1:0] int_res;
    logic [exec_pkg::xlen-1:0] link;
    exec_pkg::branch_res_t     br_res;

    int_alu u_int_alu (
        .bundle (bundle),
        .result (int_res)
    );

    branch_unit u_branch_unit (
        .bundle (bundle),
        .res    (br_res),
        .link   (link)
    );

    always_ff @(posedge clk) begin
        wb.we         <= bundle.we;
        wb.rob_idx    <= bundle.rob_idx;
        wb.rd         <= bundle.rd;
        wb.res        <= bundle.intv ? int_res : link;   // Branches write back pc + 4
        br.direction  <= br_res.direction;
        br.error      <= br_res.error;
        br.target     <= br_res.target;
        if (rst) begin
            wb.en <= 1'b0;
            br.en <= 1'b0;
        end else begin
            // Both records are single-cycle pulses, nothing downstream can stall them
            wb.en <= issue_valid;
            br.en <= issue_valid & br_res.en;
        end
    end

endmodule

//--- verilog/alu_issue_reg.sv
`timescale 1ns/10ps

module alu_issue_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  exec_pkg::issue_bundle_t in_bundle,
    output logic                    ack,
    output logic                    issue_valid,
    output exec_pkg::issue_bundle_t bundle
);

    logic accept;

    // The stage is idle whenever ack is low, so a new request is taken
    // only after the previous exchange has fully closed
    assign accept = req & ~ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack         <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept;   // One pulse per accepted micro-op
            if (accept) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;         // Requester has withdrawn
            end
        end
    end

    // Payload register, loaded only while the requester holds it stable
    always_ff @(posedge clk) begin
        if (accept) begin
            bundle <= in_bundle;
        end
    end

endmodule

//--- verilog/alu_top.sv
`timescale 1ns/10ps

module alu_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  exec_pkg::issue_bundle_t in_bundle,
    output logic                    ack,
    output exec_pkg::wb_data_t      wb,
    output exec_pkg::branch_res_t   br
);

    logic                    issue_valid;
    exec_pkg::issue_bundle_t issue_bundle;

    alu_issue_reg u_issue_reg (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .in_bundle   (in_bundle),
        .ack         (ack),
        .issue_valid (issue_valid),
        .bundle      (issue_bundle)
    );

    alu_exec u_exec (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .bundle      (issue_bundle),
        .wb          (wb),
        .br          (br)
    );

endmodule

//--- verilog/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  exec_pkg::issue_bundle_t   bundle,
    output exec_pkg::branch_res_t     res,
    output logic [exec_pkg::xlen-1:0] link
);

    logic [exec_pkg::xlen-1:0] jalr_imm;
    logic [exec_pkg::xlen-1:0] br_imm;
    logic [exec_pkg::xlen-1:0] jalr_sum;
    logic [exec_pkg::xlen-1:0] jalr_target;
    logic [exec_pkg::xlen-1:0] br_target;
    logic                      equal;
    logic                      ucmp;
    logic                      scmp;
    logic                      lt;
    logic                      dir;
    logic                      cond_error;
    logic                      jalr_error;

    assign equal = bundle.rs1_data == bundle.rs2_data;
    assign ucmp  = bundle.rs1_data < bundle.rs2_data;

    always_comb begin
        case ({bundle.rs1_data[exec_pkg::xlen-1], bundle.rs2_data[exec_pkg::xlen-1]})
            2'b01:   scmp = 1'b0;   // rs1 positive, rs2 negative
            2'b10:   scmp = 1'b1;
            default: scmp = ucmp;   // Same sign orders like unsigned
        endcase
    end

    assign lt = bundle.uext ? ucmp : scmp;

    always_comb begin
        case (bundle.br_op)
            exec_pkg::br_beq: begin
                dir = equal;
            end
            exec_pkg::br_bne: begin
                dir = ~equal;
            end
            exec_pkg::br_blt: begin
                dir = lt;
            end
            exec_pkg::br_bge: begin
                dir = ~lt;
            end
            exec_pkg::br_jal, exec_pkg::br_jalr: begin
                dir = 1'b1;
            end
            default: dir = 1'b0;
        endcase
    end

    assign jalr_imm = {{(exec_pkg::xlen-12){bundle.imm.i_form.imm[11]}}, bundle.imm.i_form.imm};
    assign br_imm   = {{(exec_pkg::xlen-13){bundle.imm.b_form.off[12]}},
                       bundle.imm.b_form.off[12:1], 1'b0};

    assign jalr_sum    = bundle.rs1_data + jalr_imm;
    assign jalr_target = {jalr_sum[exec_pkg::xlen-1:1], 1'b0};
    assign br_target   = bundle.pc + br_imm;
    assign link        = bundle.pc + 32'd4;

    // Wrong direction, or right direction to the wrong place
    assign cond_error = (bundle.pred.taken ^ dir)
                      | (bundle.pred.taken & dir & (bundle.pred.target != br_target));
    assign jalr_error = ~bundle.pred.taken | (bundle.pred.target != jalr_target);

    assign res.en        = ~bundle.intv;   // Qualified with the issue pulse by the caller
    assign res.direction = dir;
    assign res.target    = bundle.br_op == exec_pkg::br_jalr ? jalr_target :
                           dir ? br_target : link;
    assign res.error     = bundle.br_op == exec_pkg::br_jalr ? jalr_error :
                           bundle.br_op == exec_pkg::br_jal ? 1'b0 : cond_error;

endmodule

//--- verilog/exec_pkg.sv
package exec_pkg;

    localparam int xlen = 32;
    localparam int rob_idx_w = 5;
    localparam int reg_idx_w = 5;
    localparam int shamt_w = $clog2(xlen);
    localparam int imm_w = 20;

    typedef enum logic [3:0] {
        int_add,
        int_sub,
        int_lui,
        int_slt,
        int_or,
        int_xor,
        int_and,
        int_sl,
        int_sr,
        int_auipc
    } int_op_e;

    typedef enum logic [2:0] {
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_jal,
        br_jalr
    } br_op_e;

    // I-type immediate sits in the top 12 bits of the decoded word
    typedef struct packed {
        logic [11:0] imm;
        logic [7:0]  pad;
    } i_form_t;

    // Branch offset in the low 13 bits, bit 0 is always zero
    typedef struct packed {
        logic [6:0]  pad;
        logic [12:0] off;
    } b_form_t;

    typedef union packed {
        i_form_t          i_form;
        b_form_t          b_form;
        logic [imm_w-1:0] u_form;
    } dec_imm_u;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } fetch_pred_t;

    typedef struct packed {
        logic                 intv;     // Integer op, branch op otherwise
        int_op_e              int_op;
        br_op_e               br_op;
        logic                 immv;
        logic                 uext;
        dec_imm_u             imm;
        logic [xlen-1:0]      rs1_data;
        logic [xlen-1:0]      rs2_data;
        logic [xlen-1:0]      pc;
        fetch_pred_t          pred;
        logic                 we;
        logic [rob_idx_w-1:0] rob_idx;
        logic [reg_idx_w-1:0] rd;
    } issue_bundle_t;

    typedef struct packed {
        logic                 en;
        logic                 we;
        logic [rob_idx_w-1:0] rob_idx;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      res;
    } wb_data_t;

    typedef struct packed {
        logic            en;
        logic            direction;
        logic            error;       // Front end must be redirected
        logic [xlen-1:0] target;
    } branch_res_t;

endpackage

//--- verilog/int_alu.sv
`timescale 1ns/10ps

module int_alu (
    input  exec_pkg::issue_bundle_t       bundle,
    output logic [exec_pkg::xlen-1:0]     result
);

    logic [exec_pkg::xlen-1:0]     s_imm;
    logic [exec_pkg::xlen-1:0]     lui_imm;
    logic [exec_pkg::xlen-1:0]     src1;
    logic [exec_pkg::xlen-1:0]     src2;
    logic [exec_pkg::xlen-1:0]     add_src2;
    logic [exec_pkg::xlen-1:0]     add_res;
    logic [exec_pkg::xlen-1:0]     sl_res;
    logic [exec_pkg::xlen-1:0]     sr_res;
    logic [exec_pkg::xlen-1:0]     auipc_res;
    logic [2*exec_pkg::xlen-1:0]   sr_wide;
    logic [exec_pkg::shamt_w-1:0]  shamt;
    logic                          add_cin;
    logic                          add_cout;
    logic                          scmp;
    logic                          ucmp;
    logic                          padding;

    assign s_imm = {{(exec_pkg::xlen-12){bundle.imm.i_form.imm[11]}}, bundle.imm.i_form.imm};
    assign lui_imm = {bundle.imm.u_form, 12'b0};

    assign src1 = bundle.rs1_data;
    assign src2 = bundle.immv ? s_imm : bundle.rs2_data;

    // sub and slt share the adder as a + ~b + 1
    always_comb begin
        case (bundle.int_op)
            exec_pkg::int_sub, exec_pkg::int_slt: begin
                add_src2 = ~src2;
                add_cin  = 1'b1;
            end
            default: begin
                add_src2 = src2;
                add_cin  = 1'b0;
            end
        endcase
    end

    assign {add_cout, add_res} = src1 + add_src2 + {{exec_pkg::xlen{1'b0}}, add_cin};

    // Signs differ: the negative operand is smaller. Same sign: look at the difference
    assign scmp = (src1[exec_pkg::xlen-1] & ~src2[exec_pkg::xlen-1])
                | ((src1[exec_pkg::xlen-1] ~^ src2[exec_pkg::xlen-1]) & add_res[exec_pkg::xlen-1]);
    assign ucmp = ~add_cout;   // No carry out means a borrow

    assign shamt   = src2[exec_pkg::shamt_w-1:0];
    assign padding = src1[exec_pkg::xlen-1] & ~bundle.uext;
    assign sl_res  = src1 << shamt;

    // Shifting the sign-padded double word right fills the top with padding
    assign sr_wide = {{exec_pkg::xlen{padding}}, src1} >> shamt;
    assign sr_res  = sr_wide[exec_pkg::xlen-1:0];

    assign auipc_res = bundle.pc + lui_imm;

    always_comb begin
        case (bundle.int_op)
            exec_pkg::int_add, exec_pkg::int_sub: begin
                result = add_res;
            end
            exec_pkg::int_lui: begin
                result = lui_imm;
            end
            exec_pkg::int_slt: begin
                result = {{(exec_pkg::xlen-1){1'b0}}, bundle.uext ? ucmp : scmp};
            end
            exec_pkg::int_or: begin
                result = src1 | src2;
            end
            exec_pkg::int_xor: begin
                result = src1 ^ src2;
            end
            exec_pkg::int_and: begin
                result = src1 & src2;
            end
            exec_pkg::int_sl: begin
                result = sl_res;
            end
            exec_pkg::int_sr: begin
                result = sr_res;
            end
            exec_pkg::int_auipc: begin
                result = auipc_res;
            end
            default: result = '0;
        endcase
    end

endmodule
